/* design/sram_pkg.sv */
package sram_pkg;

   // ------------------------------
   // memory geometry
   // ------------------------------
   localparam int lanes   = 2;                // 32-bit tiles across the word
   localparam int tile_w  = 32;               // data bits per tile
   localparam int tile_be = tile_w / 8;       // byte enables per tile
   localparam int addr_w  = 9;                // 512 words deep

   localparam int data_w  = lanes * tile_w;   // full word, 64 bits
   localparam int strb_w  = lanes * tile_be;  // one enable per byte

   typedef logic [addr_w-1:0] addr_t;         // word address
   typedef logic [data_w-1:0] data_t;         // one memory word

   // bit i covers byte i, low nibble to tile 0, high nibble to tile 1
   typedef logic [strb_w-1:0] strobe_t;

   // ------------------------------
   // request / response payloads
   // ------------------------------

   // 1 + 9 + 8 + 64 = 82 bits
   typedef struct packed {
      logic    write;   // 1 = write, 0 = read
      addr_t   addr;
      strobe_t strobe;  // don't care on reads
      data_t   wdata;
   } mem_req_t;

   // 9 + 64 = 73 bits
   typedef struct packed {
      addr_t addr;      // echoed from the request
      data_t rdata;
   } mem_rsp_t;

endpackage

/* design/ramb16x32_tdp.sv */
`timescale 1ns/10ps

module ramb16x32_tdp (
   input  logic                              CLKA,
   // port a
   input  logic                              ena,
   input  logic [sram_pkg::tile_be-1:0]      wea,    // per-byte write enables
   input  sram_pkg::addr_t                   addra,
   input  logic [sram_pkg::tile_w-1:0]       dia,
   output logic [sram_pkg::tile_w-1:0]       doa,
   // port b
   input  logic                              enb,
   input  logic [sram_pkg::tile_be-1:0]      web,
   input  sram_pkg::addr_t                   addrb,
   input  logic [sram_pkg::tile_w-1:0]       dib,
   output logic [sram_pkg::tile_w-1:0]       dob
);

   localparam int depth = 2 ** sram_pkg::addr_w;  // 512 entries

   // one byte array per lane, shared by both ports
   logic [7:0] ram [sram_pkg::tile_be][depth];

   // output latches power up cleared, contents do not
   logic [sram_pkg::tile_w-1:0] doa_q = '0;
   logic [sram_pkg::tile_w-1:0] dob_q = '0;

   assign doa = doa_q;
   assign dob = dob_q;

   // ------------------------------
   // port a
   // ------------------------------
   always @(posedge CLKA) begin : port_a
      if (ena) begin
         for (int i = 0; i < sram_pkg::tile_be; i++) begin
            if (wea[i]) begin
               ram[i][addra] <= dia[8*i +: 8];  // byte lane write
            end
            doa_q[8*i +: 8] <= wea[i] ? dia[8*i +: 8]    // write-first
                                      : ram[i][addra];   // old byte kept
         end
      end
   end

   // ------------------------------
   // port b
   // ------------------------------
   always @(posedge CLKA) begin : port_b
      if (enb) begin
         for (int i = 0; i < sram_pkg::tile_be; i++) begin
            if (web[i]) begin
               ram[i][addrb] <= dib[8*i +: 8];
            end
            dob_q[8*i +: 8] <= web[i] ? dib[8*i +: 8]    // new data wins
                                      : ram[i][addrb];
         end
      end
   end

   // same-address writes from both ports in one cycle are left undefined

endmodule

/* design/sram_port_ctrl.sv */
`timescale 1ns/10ps

module sram_port_ctrl #(
   parameter int RD_SLOTS = 4                       // response buffer depth
) (
   input  logic               CLKA,
   input  logic               rst,
   // request channel
   input  logic               req_valid,
   output logic               req_ready,
   input  sram_pkg::mem_req_t req,
   // response channel
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output sram_pkg::mem_rsp_t rsp,
   // tile port, both tiles side by side
   output logic               ram_en,
   output sram_pkg::strobe_t  ram_we,
   output sram_pkg::addr_t    ram_addr,
   output sram_pkg::data_t    ram_wdata,
   input  sram_pkg::data_t    ram_rdata
);

   localparam int cnt_w = $clog2(RD_SLOTS + 1);             // holds 0..RD_SLOTS
   localparam int ptr_w = (RD_SLOTS > 1) ? $clog2(RD_SLOTS) : 1;

   logic [cnt_w-1:0]   credit_cnt;   // reads in flight plus buffered
   logic [cnt_w-1:0]   buf_cnt;      // entries sitting in the buffer
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;

   logic               accept;       // request transfer this edge
   logic               rd_accept;    // ... and it is a read
   logic               rsp_fire;     // response transfer this edge

   logic               rd_pend;      // tile data due next edge
   sram_pkg::addr_t    rd_pend_addr; // address to echo back
   sram_pkg::mem_rsp_t push_word;

   sram_pkg::mem_rsp_t rsp_buf [RD_SLOTS];  // circular response store

   // wrap at RD_SLOTS, depth need not be a power of two
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      if (p == ptr_w'(RD_SLOTS - 1)) begin
         return '0;
      end else begin
         return p + 1'b1;
      end
   endfunction

   // ------------------------------
   // request side
   // ------------------------------
   assign req_ready = (credit_cnt < cnt_w'(RD_SLOTS));  // state only, no valid
   assign accept    = req_valid & req_ready;
   assign rd_accept = accept & ~req.write;

   // tile driven straight from the accepted request
   assign ram_en    = accept;
   assign ram_we    = req.write ? req.strobe : '0;      // strobe only on writes
   assign ram_addr  = req.addr;
   assign ram_wdata = req.wdata;

   // credits: taken by an accepted read, returned on response transfer
   always_ff @(posedge CLKA) begin
      if (rst) begin
         credit_cnt <= '0;
      end else begin
         case ({rd_accept, rsp_fire})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            default: credit_cnt <= credit_cnt;          // none or both
         endcase
      end
   end

   // ------------------------------
   // read pipeline stage
   // ------------------------------
   always_ff @(posedge CLKA) begin
      if (rst) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= rd_accept;                          // tile registers this edge
      end
   end

   always_ff @(posedge CLKA) begin
      if (rd_accept) begin
         rd_pend_addr <= req.addr;                      // payload, no reset
      end
   end

   assign push_word = '{addr: rd_pend_addr, rdata: ram_rdata};

   // ------------------------------
   // response buffer
   // ------------------------------
   assign rsp_valid = (buf_cnt != '0);
   assign rsp       = rsp_buf[rd_ptr];                  // oldest entry
   assign rsp_fire  = rsp_valid & rsp_ready;

   // credits bound the fill, so a push never finds it full
   always_ff @(posedge CLKA) begin
      if (rd_pend) begin
         rsp_buf[wr_ptr] <= push_word;
      end
   end

   always_ff @(posedge CLKA) begin
      if (rst) begin
         wr_ptr <= '0;
      end else if (rd_pend) begin
         wr_ptr <= ptr_inc(wr_ptr);
      end
   end

   always_ff @(posedge CLKA) begin
      if (rst) begin
         rd_ptr <= '0;
      end else if (rsp_fire) begin
         rd_ptr <= ptr_inc(rd_ptr);                     // in order
      end
   end

   always_ff @(posedge CLKA) begin
      if (rst) begin
         buf_cnt <= '0;
      end else begin
         case ({rd_pend, rsp_fire})
            2'b10:   buf_cnt <= buf_cnt + 1'b1;         // push only
            2'b01:   buf_cnt <= buf_cnt - 1'b1;         // pop only
            default: buf_cnt <= buf_cnt;
         endcase
      end
   end

   // pop needs a non-empty buffer, so no bypass path from push to rsp

endmodule

/* design/wide_sram_dp.sv */
`timescale 1ns/10ps

module wide_sram_dp #(
   parameter int RD_SLOTS = 4                     // response depth per port
) (
   input  logic               CLKA,
   input  logic               rst,
   // port a
   input  logic               a_req_valid,
   input  sram_pkg::mem_req_t a_req,
   output logic               a_req_ready,
   output logic               a_rsp_valid,
   output sram_pkg::mem_rsp_t a_rsp,
   input  logic               a_rsp_ready,
   // port b
   input  logic               b_req_valid,
   input  sram_pkg::mem_req_t b_req,
   output logic               b_req_ready,
   output logic               b_rsp_valid,
   output sram_pkg::mem_rsp_t b_rsp,
   input  logic               b_rsp_ready
);

   localparam int bw = sram_pkg::tile_w;          // tile data width
   localparam int sw = sram_pkg::tile_be;         // tile strobe width

   // controller a to tile port a
   logic              a_en;
   sram_pkg::strobe_t a_we;
   sram_pkg::addr_t   a_addr;
   sram_pkg::data_t   a_wdata;
   sram_pkg::data_t   a_rdata;

   // controller b to tile port b
   logic              b_en;
   sram_pkg::strobe_t b_we;
   sram_pkg::addr_t   b_addr;
   sram_pkg::data_t   b_wdata;
   sram_pkg::data_t   b_rdata;

   // ------------------------------
   // port controllers
   // ------------------------------
   sram_port_ctrl #(.RD_SLOTS(RD_SLOTS)) port_a (
      .CLKA      (CLKA),
      .rst       (rst),
      .req_valid (a_req_valid),
      .req_ready (a_req_ready),
      .req       (a_req),
      .rsp_valid (a_rsp_valid),
      .rsp_ready (a_rsp_ready),
      .rsp       (a_rsp),
      .ram_en    (a_en),
      .ram_we    (a_we),
      .ram_addr  (a_addr),
      .ram_wdata (a_wdata),
      .ram_rdata (a_rdata)
   );

   sram_port_ctrl #(.RD_SLOTS(RD_SLOTS)) port_b (
      .CLKA      (CLKA),
      .rst       (rst),
      .req_valid (b_req_valid),
      .req_ready (b_req_ready),
      .req       (b_req),
      .rsp_valid (b_rsp_valid),
      .rsp_ready (b_rsp_ready),
      .rsp       (b_rsp),
      .ram_en    (b_en),
      .ram_we    (b_we),
      .ram_addr  (b_addr),
      .ram_wdata (b_wdata),
      .ram_rdata (b_rdata)
   );

   // ------------------------------
   // tiles, low and high halves
   // ------------------------------
   ramb16x32_tdp tile_lo (
      .CLKA  (CLKA),
      .ena   (a_en),
      .wea   (a_we[sw-1:0]),                      // bytes 0..3
      .addra (a_addr),
      .dia   (a_wdata[bw-1:0]),
      .doa   (a_rdata[bw-1:0]),
      .enb   (b_en),
      .web   (b_we[sw-1:0]),
      .addrb (b_addr),
      .dib   (b_wdata[bw-1:0]),
      .dob   (b_rdata[bw-1:0])
   );

   ramb16x32_tdp tile_hi (
      .CLKA  (CLKA),
      .ena   (a_en),                              // same enable, both lanes
      .wea   (a_we[2*sw-1:sw]),                   // bytes 4..7
      .addra (a_addr),
      .dia   (a_wdata[2*bw-1:bw]),
      .doa   (a_rdata[2*bw-1:bw]),
      .enb   (b_en),
      .web   (b_we[2*sw-1:sw]),
      .addrb (b_addr),
      .dib   (b_wdata[2*bw-1:bw]),
      .dob   (b_rdata[2*bw-1:bw])
   );

endmodule

/* tb/wide_sram_sva.sv */
`timescale 1ns/10ps

module wide_sram_sva #(
   parameter int RD_SLOTS = 4
) (
   input logic               CLKA,
   input logic               rst,
   input logic               a_req_valid,
   input logic               a_req_ready,
   input sram_pkg::mem_req_t a_req,
   input logic               a_rsp_valid,
   input logic               a_rsp_ready,
   input sram_pkg::mem_rsp_t a_rsp,
   input logic               b_req_valid,
   input logic               b_req_ready,
   input sram_pkg::mem_req_t b_req,
   input logic               b_rsp_valid,
   input logic               b_rsp_ready,
   input sram_pkg::mem_rsp_t b_rsp
);

   int a_out = 0;   // reads accepted, response not yet taken
   int b_out = 0;

   always_ff @(posedge CLKA) begin
      if (rst) begin
         a_out <= 0;
         b_out <= 0;
      end else begin
         a_out <= a_out + int'(a_req_valid & a_req_ready & ~a_req.write)
                        - int'(a_rsp_valid & a_rsp_ready);
         b_out <= b_out + int'(b_req_valid & b_req_ready & ~b_req.write)
                        - int'(b_rsp_valid & b_rsp_ready);
      end
   end

   // held request stays put until taken
   a_hold: assert property (@(posedge CLKA) disable iff (rst)
      a_req_valid && !a_req_ready |=> a_req_valid && $stable(a_req))
      else $error("port a request dropped or changed while stalled");
   b_hold: assert property (@(posedge CLKA) disable iff (rst)
      b_req_valid && !b_req_ready |=> b_req_valid && $stable(b_req))
      else $error("port b request dropped or changed while stalled");

   // stalled response keeps its word until the consumer takes it
   a_rsp_hold: assert property (@(posedge CLKA) disable iff (rst)
      a_rsp_valid && !a_rsp_ready |=> a_rsp_valid && $stable(a_rsp))
      else $error("port a response dropped or changed while stalled");
   b_rsp_hold: assert property (@(posedge CLKA) disable iff (rst)
      b_rsp_valid && !b_rsp_ready |=> b_rsp_valid && $stable(b_rsp))
      else $error("port b response dropped or changed while stalled");

   rsp_idle: assert property (@(posedge CLKA) $fell(rst) |-> !a_rsp_valid && !b_rsp_valid)
      else $error("response valid right after reset");

   a_slots: assert property (@(posedge CLKA) disable iff (rst) a_out <= RD_SLOTS)
      else $error("port a has too many outstanding reads");
   b_slots: assert property (@(posedge CLKA) disable iff (rst) b_out <= RD_SLOTS)
      else $error("port b has too many outstanding reads");

endmodule

bind wide_sram_dp wide_sram_sva #(.RD_SLOTS(RD_SLOTS)) sva (.*);

/* include/wide_sram_tb_cfg.svh */
`ifndef WIDE_SRAM_TB_CFG_SVH
`define WIDE_SRAM_TB_CFG_SVH

// ------------------------------
// testbench run limits
// ------------------------------

// cycles to wait on any ready or valid before giving up
localparam int tb_timeout_cycles = 1000;

// $random seed for the mixed traffic test
localparam logic [31:0] tb_seed = 32'h5b;

// requests issued per port in the random test
localparam int tb_rand_ops = 400;

`endif

/* tb/wide_sram_tb.sv */
`timescale 1ns/10ps

module wide_sram_tb;

`include "wide_sram_tb_cfg.svh"

   localparam int depth = 2 ** sram_pkg::addr_w;

   logic               CLKA;
   logic               rst;
   logic               a_req_valid, a_req_ready, a_rsp_valid, a_rsp_ready;
   logic               b_req_valid, b_req_ready, b_rsp_valid, b_rsp_ready;
   sram_pkg::mem_req_t a_req, b_req;
   sram_pkg::mem_rsp_t a_rsp, b_rsp;

   sram_pkg::data_t    model [depth];      // reference memory
   sram_pkg::mem_rsp_t exp_a [$];          // expected responses, port a
   sram_pkg::mem_rsp_t exp_b [$];
   int                 errors   = 0;
   int                 timeouts = 0;
   int                 seed     = tb_seed;

   wide_sram_dp #(.RD_SLOTS(4)) dut (.*);

   initial begin
      CLKA = 1'b0;
      forever #5 CLKA = ~CLKA;             // 10 ns period
   end

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_rsp(input string name, input sram_pkg::mem_rsp_t exp,
                            input sram_pkg::mem_rsp_t act);
      if (act !== exp) begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("mismatch %s expected %b actual %b", name, exp, act);
      end
   endtask

   // ------------------------------
   // port access helpers
   // ------------------------------
   function automatic sram_pkg::data_t merge(input sram_pkg::data_t old_w,
                                             input sram_pkg::data_t new_w,
                                             input sram_pkg::strobe_t strb);
      sram_pkg::data_t w;
      w = old_w;
      for (int i = 0; i < 8; i++) begin
         if (strb[i]) w[8*i +: 8] = new_w[8*i +: 8];   // byte i follows bit i
      end
      return w;
   endfunction

   task automatic set_req(input int p, input logic v, input sram_pkg::mem_req_t r);
      if (p == 0) begin
         a_req_valid = v;
         a_req       = r;
      end else begin
         b_req_valid = v;
         b_req       = r;
      end
   endtask

   task automatic set_rsp_ready(input int p, input logic v);
      if (p == 0) a_rsp_ready = v;
      else        b_rsp_ready = v;
   endtask

   function automatic logic ready_of(input int p);
      return (p == 0) ? a_req_ready : b_req_ready;
   endfunction

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send_req(input int p, input sram_pkg::mem_req_t r);
      int n;
      n = 0;
      set_req(p, 1'b1, r);
      while (!ready_of(p) && n < tb_timeout_cycles) begin
         @(negedge CLKA);
         n++;
      end
      if (!ready_of(p)) begin
         timeouts++;
         $display("timeout: request on port %0d was never accepted", p);
         set_req(p, 1'b0, '0);
         return;
      end
      @(posedge CLKA);                      // transfer edge
      if (r.write) begin
         model[r.addr] = merge(model[r.addr], r.wdata, r.strobe);
      end else if (p == 0) begin
         exp_a.push_back('{addr: r.addr, rdata: model[r.addr]});
      end else begin
         exp_b.push_back('{addr: r.addr, rdata: model[r.addr]});
      end
      @(negedge CLKA);
      set_req(p, 1'b0, '0);
   endtask

   task automatic write_word(input int p, input sram_pkg::addr_t ad,
                             input sram_pkg::data_t d, input sram_pkg::strobe_t s);
      send_req(p, '{write: 1'b1, addr: ad, strobe: s, wdata: d});
   endtask

   task automatic read_word(input int p, input sram_pkg::addr_t ad);
      send_req(p, '{write: 1'b0, addr: ad, strobe: '0, wdata: '0});
   endtask

   // collect n responses, optionally with random rsp_ready stalls
   task automatic drain(input string name, input int p, input int n, input bit stall);
      int                 got;
      int                 idle;
      logic               rdy;
      logic               vld;
      sram_pkg::mem_rsp_t exp;
      sram_pkg::mem_rsp_t act;
      got  = 0;
      idle = 0;
      while (got < n && idle < tb_timeout_cycles) begin
         rdy = stall ? (($random(seed) & 3) != 0) : 1'b1;
         set_rsp_ready(p, rdy);
         vld = (p == 0) ? a_rsp_valid : b_rsp_valid;
         act = (p == 0) ? a_rsp : b_rsp;
         if (vld && rdy) begin
            if ((p == 0 ? exp_a.size() : exp_b.size()) == 0) begin
               errors++;
               $display("%s: port %0d returned a response nobody asked for", name, p);
            end else begin
               exp = (p == 0) ? exp_a.pop_front() : exp_b.pop_front();
               check_rsp(name, exp, act);
            end
            got++;
            idle = 0;
         end else begin
            idle++;
         end
         @(negedge CLKA);
      end
      set_rsp_ready(p, 1'b1);
      if (got < n) begin
         timeouts++;
         $display("timeout: %s got only %0d of %0d responses on port %0d", name, got, n, p);
      end
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic test_reset();
      check_flag("reset a_req_ready", 1'b1, a_req_ready);
      check_flag("reset b_req_ready", 1'b1, b_req_ready);
      check_flag("reset a_rsp_valid", 1'b0, a_rsp_valid);
      check_flag("reset b_rsp_valid", 1'b0, b_rsp_valid);
   endtask

   task automatic test_full_word();
      for (int i = 0; i < 4; i++) begin
         write_word(0, 9'h020 + i, {$random(seed), $random(seed)}, 8'hff);
      end
      for (int i = 0; i < 4; i++) begin
         read_word(0, 9'h020 + i);
         check_flag("full_word early valid", 1'b0, a_rsp_valid);  // 1 cycle after accept
         @(negedge CLKA);
         check_flag("full_word latency", 1'b1, a_rsp_valid);      // 2 cycles after accept
         drain("full_word", 0, 1, 1'b0);
      end
   endtask

   task automatic test_strobes();
      sram_pkg::strobe_t strb [8] = '{8'h01, 8'h80, 8'h0f, 8'hf0,
                                      8'h5a, 8'ha5, 8'h3c, 8'h00};
      for (int i = 0; i < 8; i++) begin
         write_word(0, 9'h030 + i, 64'h0123_4567_89ab_cdef ^ i, 8'hff);  // base
         write_word(0, 9'h030 + i, {$random(seed), $random(seed)}, strb[i]);
      end
      fork
         begin
            for (int i = 0; i < 8; i++) read_word(0, 9'h030 + i);
         end
         drain("strobes", 0, 8, 1'b0);     // collects while reads stream in
      join
   endtask

   task automatic test_cross_port();
      for (int i = 0; i < 4; i++) begin
         write_word(0, 9'h050 + i, {$random(seed), $random(seed)}, 8'hff);
         write_word(1, 9'h058 + i, {$random(seed), $random(seed)}, 8'hff);
      end
      fork
         begin
            for (int i = 0; i < 4; i++) begin
               read_word(1, 9'h050 + i);    // a wrote, b reads
               read_word(0, 9'h058 + i);
            end
         end
         drain("cross_b", 1, 4, 1'b0);
         drain("cross_a", 0, 4, 1'b0);
      join
   endtask

   task automatic test_backpressure();
      for (int i = 0; i < 5; i++) begin
         write_word(1, 9'h060 + i, {$random(seed), $random(seed)}, 8'hff);
      end
      b_rsp_ready = 1'b0;
      for (int i = 0; i < 4; i++) read_word(1, 9'h060 + i);
      check_flag("backpressure req_ready", 1'b0, b_req_ready);     // 4 credits taken
      fork
         read_word(1, 9'h064);
         drain("backpressure", 1, 5, 1'b0);
      join
   endtask

   task automatic random_port(input int p, input sram_pkg::mem_req_t ops [$]);
      foreach (ops[i]) send_req(p, ops[i]);
   endtask

   task automatic test_random();
      sram_pkg::mem_req_t ops_a [$];
      sram_pkg::mem_req_t ops_b [$];
      sram_pkg::mem_req_t r;
      int                 reads_a, reads_b;
      reads_a = 0;
      reads_b = 0;
      for (int i = 0; i < 16; i++) begin    // known contents first
         write_word(0, 9'h000 + i, {$random(seed), $random(seed)}, 8'hff);
         write_word(1, 9'h100 + i, {$random(seed), $random(seed)}, 8'hff);
      end
      for (int i = 0; i < 2 * tb_rand_ops; i++) begin
         r.write  = $random(seed) & 1;
         r.addr   = {(i % 2 == 1), 4'h0, 4'($random(seed))};  // b in the upper half
         r.strobe = 8'($random(seed));
         r.wdata  = {$random(seed), $random(seed)};
         if (i % 2 == 0) begin
            ops_a.push_back(r);
            reads_a += !r.write;
         end else begin
            ops_b.push_back(r);
            reads_b += !r.write;
         end
      end
      fork
         random_port(0, ops_a);
         random_port(1, ops_b);
         drain("random_a", 0, reads_a, 1'b1);
         drain("random_b", 1, reads_b, 1'b1);
      join
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      rst         = 1'b1;
      a_req_valid = 1'b0;
      a_req       = '0;
      a_rsp_ready = 1'b1;
      b_req_valid = 1'b0;
      b_req       = '0;
      b_rsp_ready = 1'b1;
      repeat (4) @(posedge CLKA);           // reset seen on 4 rising edges
      @(negedge CLKA);
      rst = 1'b0;
      test_reset();
      test_full_word();
      test_strobes();
      test_cross_port();
      test_backpressure();
      test_random();
      repeat (4) @(negedge CLKA);
      $display("errors %0d, timeouts %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+include
design/sram_pkg.sv
design/ramb16x32_tdp.sv
design/sram_port_ctrl.sv
design/wide_sram_dp.sv
tb/wide_sram_sva.sv
tb/wide_sram_tb.sv

/* Makefile */
# Verilator build and run for the wide dual-port SRAM

VERILATOR ?= verilator
TOP       ?= wide_sram_tb
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST) $(shell grep -v '^+' $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
